// ==== files.f ====
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_data_path.sv
hdl/main_memory.sv
hdl/cache_top.sv
test/tb_cache_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_top -f files.f -o sim_cache

# the log decides pass or fail
./obj_dir/sim_cache > sim.log 2>&1 || true
cat sim.log

if grep -q -- '>>> FAIL' sim.log; then
    exit 1
fi
grep -q -- '>>> PASS' sim.log

// ==== test/tb_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int NUM_REQ = 600;
    localparam int MAX_CYC = NUM_REQ * 20 + 2000;
    localparam int SEED    = 97;

    logic  clk;
    logic  rst;
    logic  req_valid;
    logic  req_ready;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    logic  resp_valid;
    word_t resp_rdata;
    logic  resp_hit;
    logic  flush_req;
    logic  flush_done;

    // reference model
    word_t      mem_img   [MEM_DEPTH];
    logic       tab_valid [NUM_LINES];
    logic [3:0] tab_tag   [NUM_LINES];

    int cycle_cnt = 0;
    int n_hit;
    int n_flush;

    cache_top u_dut (
        .clk, .rst, .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
        .resp_valid, .resp_rdata, .resp_hit, .flush_req, .flush_done
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYC) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYC);
            stop_failed();
        end
    end

    task automatic stop_failed();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_failed();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;   // drive point, outputs settled
    endtask

    task automatic idle_cycle();
        next_cycle();
        compare_bit("resp_valid", resp_valid, 1'b0);
        compare_bit("flush_done", flush_done, 1'b0);
        compare_bit("req_ready", req_ready, 1'b1);
    endtask

    task automatic do_request(input logic wr, input logic [3:0] tag, input index_t idx,
                              input word_t wdata);
        mem_addr_t waddr;
        logic      exp_hit;
        word_t     exp_data;
        int        cyc;
        waddr    = {tag, idx};
        exp_hit  = tab_valid[idx] && (tab_tag[idx] == tag);
        exp_data = wr ? wdata : mem_img[waddr];
        compare_bit("req_ready", req_ready, 1'b1);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr_t'({tag, idx}) << INDEX_LSB;
        req_wdata = wdata;
        next_cycle();
        req_valid = 1'b0;
        cyc = 1;   // lookup cycle
        while (!resp_valid) begin
            compare_bit("req_ready", req_ready, 1'b0);
            compare_bit("flush_done", flush_done, 1'b0);
            next_cycle();
            cyc++;
        end
        compare_bit("req_ready", req_ready, 1'b0);
        compare_bit("resp_hit", resp_hit, exp_hit);
        compare_word("resp_rdata", resp_rdata, exp_data);
        if (exp_hit && cyc != 2) begin
            $display("hit response came %0d cycles after acceptance instead of 2", cyc);
            stop_failed();
        end
        if (wr)
            mem_img[waddr] = wdata;
        tab_valid[idx] = 1'b1;   // write-allocate on both kinds
        tab_tag[idx]   = tag;
        if (exp_hit)
            n_hit++;
        idle_cycle();   // single pulse, ready again
    endtask

    task automatic do_flush();
        compare_bit("req_ready", req_ready, 1'b1);
        flush_req = 1'b1;
        next_cycle();
        flush_req = 1'b0;
        while (!flush_done) begin
            compare_bit("resp_valid", resp_valid, 1'b0);
            compare_bit("req_ready", req_ready, 1'b0);
            next_cycle();
        end
        compare_bit("resp_valid", resp_valid, 1'b0);
        for (int i = 0; i < NUM_LINES; i++)
            tab_valid[i] = 1'b0;
        n_flush++;
        idle_cycle();   // flush_done must drop
    endtask

    initial begin
        logic       wr;
        logic [3:0] tag;
        index_t     idx;
        word_t      wd;
        int         gap;
        void'($urandom(SEED));
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        flush_req = 1'b0;
        n_hit     = 0;
        n_flush   = 0;
        for (int w = 0; w < MEM_DEPTH; w++)
            mem_img[w] = MEM_INIT_BASE + word_t'(w);
        for (int i = 0; i < NUM_LINES; i++) begin
            tab_valid[i] = 1'b0;
            tab_tag[i]   = '0;
        end
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        compare_bit("req_ready", req_ready, 1'b1);

        do_request(1'b0, 4'h5, 2'd1, '0);             // cold miss
        do_request(1'b1, 4'h5, 2'd1, 32'hcafe_0001);  // write hit
        do_request(1'b0, 4'h5, 2'd1, '0);             // read hit
        do_request(1'b1, 4'h9, 2'd1, 32'hbeef_0002);  // evicts dirty line
        do_request(1'b0, 4'h5, 2'd1, '0);             // written-back word
        do_flush();
        do_request(1'b0, 4'h9, 2'd1, '0);

        for (int n = 0; n < NUM_REQ; n++) begin
            gap = $urandom_range(2, 0);
            repeat (gap) idle_cycle();
            if ($urandom_range(15, 0) == 0)
                do_flush();
            wr  = 1'($urandom_range(1, 0));
            // mostly a few tags per index so hits happen
            tag = ($urandom_range(3, 0) == 0) ? 4'($urandom_range(15, 0))
                                              : 4'($urandom_range(3, 0));
            idx = index_t'($urandom_range(3, 0));
            wd  = $urandom;
            do_request(wr, tag, idx, wd);
        end

        $display("%0d random requests, %0d hits, %0d flushes", NUM_REQ, n_hit, n_flush);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    output logic             req_ready,
    input  logic             req_write,
    input  cache_pkg::addr_t req_addr,
    input  cache_pkg::word_t req_wdata,
    output logic             resp_valid,
    output cache_pkg::word_t resp_rdata,
    output logic             resp_hit,
    input  logic             flush_req,
    output logic             flush_done
);
    import cache_pkg::*;
    import mem_pkg::*;

    logic      hit;
    logic      line_valid;
    logic      line_dirty;
    logic      req_is_write;
    logic      latch_req;
    logic      fill_en;
    logic      cpu_write_en;
    index_t    line_sel;
    logic      use_line_sel;
    logic      inval_all;

    logic      mem_req_valid;
    logic      mem_req_ready;
    logic      mem_write;
    logic      mem_resp_valid;
    mem_addr_t victim_addr;
    mem_addr_t fetch_addr;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;

    assign mem_addr = mem_write ? victim_addr : fetch_addr;   // write-back uses stored tag

    cache_ctrl u_ctrl (
        .clk, .rst, .req_valid, .flush_req, .hit, .line_valid, .line_dirty,
        .req_is_write, .mem_req_ready, .mem_resp_valid, .req_ready, .resp_valid,
        .resp_hit, .flush_done, .latch_req, .fill_en, .cpu_write_en, .line_sel,
        .use_line_sel, .inval_all, .mem_req_valid, .mem_write
    );

    cache_data_path u_data_path (
        .clk, .rst, .req_addr, .req_wdata, .latch_req, .req_write, .fill_en,
        .cpu_write_en, .line_sel, .use_line_sel, .inval_all, .mem_rdata,
        .hit, .line_valid, .line_dirty, .req_is_write, .victim_addr,
        .mem_addr  (fetch_addr),
        .mem_wdata,
        .resp_rdata
    );

    main_memory u_mem (
        .clk, .rst, .mem_req_valid, .mem_write, .mem_addr, .mem_wdata,
        .mem_req_ready, .mem_resp_valid, .mem_rdata
    );

endmodule

`default_nettype wire

// ==== hdl/main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_memory (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_req_valid,
    input  logic               mem_write,
    input  mem_pkg::mem_addr_t mem_addr,
    input  cache_pkg::word_t   mem_wdata,
    output logic               mem_req_ready,
    output logic               mem_resp_valid,
    output cache_pkg::word_t   mem_rdata
);
    import cache_pkg::*;
    import mem_pkg::*;

    word_t     mem [MEM_DEPTH];
    logic      busy;
    lat_cnt_t  cnt;
    mem_addr_t addr_q;
    word_t     wdata_q;
    logic      write_q;

    assign mem_req_ready  = !busy;
    assign mem_resp_valid = busy && (cnt == lat_cnt_t'(MEM_LATENCY - 1));
    assign mem_rdata      = mem[addr_q];   // valid with mem_resp_valid

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= MEM_INIT_BASE + word_t'(i);
            end
        end else if (!busy) begin
            if (mem_req_valid) begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end else if (mem_resp_valid) begin
            busy <= 1'b0;
            if (write_q)
                mem[addr_q] <= wdata_q;   // write lands with the ack
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req_valid && mem_req_ready) begin
            addr_q  <= mem_addr;
            wdata_q <= mem_wdata;
            write_q <= mem_write;
        end
    end

    a_resp_latency: assert property (@(posedge clk) disable iff (rst)
        mem_resp_valid |-> $past(mem_req_valid && mem_req_ready, MEM_LATENCY));

endmodule

`default_nettype wire

// ==== hdl/cache_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_data_path (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::addr_t    req_addr,
    input  cache_pkg::word_t    req_wdata,
    input  logic                latch_req,
    input  logic                req_write,
    input  logic                fill_en,
    input  logic                cpu_write_en,
    input  cache_pkg::index_t   line_sel,
    input  logic                use_line_sel,
    input  logic                inval_all,
    input  cache_pkg::word_t    mem_rdata,
    output logic                hit,
    output logic                line_valid,
    output logic                line_dirty,
    output logic                req_is_write,
    output mem_pkg::mem_addr_t  victim_addr,
    output mem_pkg::mem_addr_t  mem_addr,
    output cache_pkg::word_t    mem_wdata,
    output cache_pkg::word_t    resp_rdata
);
    import cache_pkg::*;
    import mem_pkg::*;

    tag_t   tag_mem  [NUM_LINES];
    word_t  data_mem [NUM_LINES];
    logic   [NUM_LINES-1:0] valid_q;
    logic   [NUM_LINES-1:0] dirty_q;

    // latched request
    tag_t   req_tag_q;
    index_t req_idx_q;
    word_t  req_wdata_q;
    logic   req_write_q;

    index_t sel_idx;

    assign sel_idx = use_line_sel ? line_sel : req_idx_q;   // flush walks lines

    assign line_valid   = valid_q[sel_idx];
    assign line_dirty   = dirty_q[sel_idx];
    assign hit          = line_valid && (tag_mem[sel_idx] == req_tag_q);
    assign req_is_write = req_write_q;

    assign victim_addr = {tag_mem[sel_idx][MEM_TAG_BITS-1:0], sel_idx};
    assign mem_addr    = {req_tag_q[MEM_TAG_BITS-1:0], req_idx_q};   // fetch address
    assign mem_wdata   = data_mem[sel_idx];
    assign resp_rdata  = data_mem[sel_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_write_q <= 1'b0;
        end else if (latch_req) begin
            req_write_q <= req_write;
        end
    end

    always_ff @(posedge clk) begin
        if (latch_req) begin
            req_tag_q   <= req_addr[31:TAG_LSB];
            req_idx_q   <= req_addr[INDEX_LSB +: $bits(index_t)];
            req_wdata_q <= req_wdata;
        end
    end

    // line state bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_en) begin
                dirty_q[sel_idx] <= 1'b0;
                if (!use_line_sel)
                    valid_q[sel_idx] <= 1'b1;   // flush write-back keeps valid
            end
            if (cpu_write_en) begin
                valid_q[sel_idx] <= 1'b1;
                dirty_q[sel_idx] <= 1'b1;
            end
            if (inval_all)
                valid_q <= '0;
        end
    end

    // tag and data payload
    always_ff @(posedge clk) begin
        if (fill_en && !use_line_sel) begin
            data_mem[sel_idx] <= mem_rdata;
            tag_mem[sel_idx]  <= req_tag_q;
        end
        if (cpu_write_en) begin
            data_mem[sel_idx] <= req_wdata_q;
            tag_mem[sel_idx]  <= req_tag_q;
        end
    end

    a_fill_write_excl: assert property (@(posedge clk) disable iff (rst)
        !(fill_en && cpu_write_en));

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  logic              flush_req,
    input  logic              hit,
    input  logic              line_valid,
    input  logic              line_dirty,
    input  logic              req_is_write,
    input  logic              mem_req_ready,
    input  logic              mem_resp_valid,
    output logic              req_ready,
    output logic              resp_valid,
    output logic              resp_hit,
    output logic              flush_done,
    output logic              latch_req,
    output logic              fill_en,
    output logic              cpu_write_en,
    output cache_pkg::index_t line_sel,
    output logic              use_line_sel,
    output logic              inval_all,
    output logic              mem_req_valid,
    output logic              mem_write
);
    import cache_pkg::*;

    ctrl_state_t state, state_nxt;
    index_t      flush_idx;
    logic        mem_busy;      // request accepted, waiting for resp
    logic        resp_hit_q;
    logic        victim_dirty;
    logic        flush_last;

    assign victim_dirty = line_valid && line_dirty;
    assign flush_last   = (flush_idx == index_t'(NUM_LINES - 1));

    assign req_ready    = (state == st_idle);
    assign latch_req    = (state == st_idle) && req_valid;
    assign resp_valid   = (state == st_respond);
    assign resp_hit     = resp_hit_q;
    assign line_sel     = flush_idx;
    assign use_line_sel = (state == st_flush_check) || (state == st_flush_write);

    assign mem_write     = (state == st_write_back) || (state == st_flush_write);
    assign mem_req_valid = !mem_busy && (mem_write || (state == st_fetch));

    assign fill_en = mem_resp_valid && ((state == st_fetch) || (state == st_flush_write));

    // write hit, clean write miss, or write miss after its write-back
    assign cpu_write_en = req_is_write &&
        (((state == st_lookup) && (hit || !victim_dirty)) ||
         ((state == st_write_back) && mem_resp_valid));

    assign flush_done = flush_last &&
        (((state == st_flush_check) && !victim_dirty) ||
         ((state == st_flush_write) && mem_resp_valid));
    assign inval_all  = flush_done;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req_valid)
                    state_nxt = st_lookup;
                else if (flush_req)
                    state_nxt = st_flush_check;
            end
            st_lookup: begin
                if (hit || (!victim_dirty && req_is_write))
                    state_nxt = st_respond;
                else if (victim_dirty)
                    state_nxt = st_write_back;
                else
                    state_nxt = st_fetch;
            end
            st_write_back: begin
                if (mem_resp_valid)
                    state_nxt = req_is_write ? st_respond : st_fetch;
            end
            st_fetch: begin
                if (mem_resp_valid)
                    state_nxt = st_respond;
            end
            st_respond:
                state_nxt = st_idle;
            st_flush_check: begin
                if (victim_dirty)
                    state_nxt = st_flush_write;
                else if (flush_last)
                    state_nxt = st_idle;
            end
            st_flush_write: begin
                if (mem_resp_valid)
                    state_nxt = flush_last ? st_idle : st_flush_check;
            end
            default:
                state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            flush_idx  <= '0;
            mem_busy   <= 1'b0;
            resp_hit_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_idle)
                flush_idx <= '0;
            else if ((state == st_flush_check && !victim_dirty) ||
                     (state == st_flush_write && mem_resp_valid))
                flush_idx <= flush_idx + 1'b1;   // next line
            if (mem_resp_valid)
                mem_busy <= 1'b0;
            else if (mem_req_valid && mem_req_ready)
                mem_busy <= 1'b1;
            if (state == st_lookup)
                resp_hit_q <= hit;
        end
    end

    a_resp_mem_done: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !(mem_busy || mem_resp_valid));

    a_idle_no_mem: assert property (@(posedge clk) disable iff (rst)
        (state == st_idle) |-> !(mem_busy || mem_resp_valid));

endmodule

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int MEM_DEPTH    = 64;
    localparam int MEM_LATENCY  = 3;     // accept to resp_valid
    localparam int MEM_TAG_BITS = 4;     // tag bits 13..10 reach memory

    localparam logic [31:0] MEM_INIT_BASE = 32'h1000_0000;

    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;          // {tag[3:0], index}
    typedef logic [$clog2(MEM_LATENCY+1)-1:0] lat_cnt_t;

endpackage

`default_nettype wire

// ==== hdl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // cache geometry
    localparam int NUM_LINES = 4;
    localparam int TAG_LSB   = 10;
    localparam int INDEX_LSB = 8;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    typedef logic [31-TAG_LSB:0] tag_t;                // addr 31..10
    typedef logic [$clog2(NUM_LINES)-1:0] index_t;     // addr 9..8

    // controller sequence
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_fetch,
        st_respond,
        st_flush_check,
        st_flush_write
    } ctrl_state_t;

endpackage

`default_nettype wire
